//--- rtl/burst_split_config.svh
/* Bus widths, outstanding burst depth and AXI encodings shared by the burst splitter.
   BS_MAX_TXNS sets the depth of both beat-count FIFOs. */
`ifndef BURST_SPLIT_CONFIG_SVH
`define BURST_SPLIT_CONFIG_SVH

// Bus widths
`define BS_ADDR_W 32
`define BS_DATA_W 32
`define BS_ID_W   4

// Bursts outstanding per channel
`define BS_MAX_TXNS 4

// Response codes, bit 1 marks an error
`define BS_RESP_OKAY   2'b00
`define BS_RESP_SLVERR 2'b10

// Burst types, WRAP is not supported
`define BS_BURST_FIXED 2'b00
`define BS_BURST_INCR  2'b01

`endif

//--- rtl/burst_split_pkg.sv
/* Types for the burst splitter; widths come from the config header. */
`default_nettype none

`include "burst_split_config.svh"

package burst_split_pkg;

  // Bus fields
  typedef logic [`BS_ADDR_W-1:0]   addr_t;
  typedef logic [`BS_DATA_W-1:0]   data_t;
  typedef logic [`BS_DATA_W/8-1:0] strb_t;
  typedef logic [`BS_ID_W-1:0]     id_t;

  // AXI control fields
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // Remaining beats of a burst, one bit wider than len_t to hold 256
  typedef logic [8:0] cnt_t;

  // FSM states
  typedef enum logic {Idle, Busy} ax_state_e;
  typedef enum logic {BReady, BWait} b_state_e;
  typedef enum logic {RFeed, RWait} r_state_e;

endpackage

`default_nettype wire

//--- rtl/ax_splitter.sv
/* Splits one AW or AR burst into single-beat requests. WRAP bursts are not handled
   and are treated like FIXED ones. */
`timescale 1ns/100ps
`default_nettype none

`include "burst_split_config.svh"

module ax_splitter import burst_split_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  // Upstream address channel
  input  wire addr_t  ax_addr_i,
  input  wire id_t    ax_id_i,
  input  wire len_t   ax_len_i,
  input  wire size_t  ax_size_i,
  input  wire burst_t ax_burst_i,
  input  wire logic   ax_valid_i,
  output logic        ax_ready_o,
  // Downstream address channel
  output addr_t       m_addr_o,
  output id_t         m_id_o,
  output len_t        m_len_o,
  output size_t       m_size_o,
  output burst_t      m_burst_o,
  output logic        m_valid_o,
  input  wire logic   m_ready_i,
  // Beat count FIFO
  output logic        cnt_push_o,
  output len_t        cnt_len_o,
  input  wire logic   cnt_full_i
);

  ax_state_e state_q, state_d;
  addr_t     addr_q, addr_d;
  id_t       id_q, id_d;
  len_t      len_q, len_d;
  size_t     size_q, size_d;
  burst_t    burst_q, burst_d;

  // Address of the beat after this one
  function automatic addr_t next_addr(addr_t addr, size_t size, burst_t burst);
    if (burst == `BS_BURST_INCR) begin
      return addr + (addr_t'(1) << size);
    end
    return addr;
  endfunction

  always_comb begin
    state_d    = state_q;
    addr_d     = addr_q;
    id_d       = id_q;
    len_d      = len_q;
    size_d     = size_q;
    burst_d    = burst_q;
    ax_ready_o = 1'b0;
    m_addr_o   = addr_q;
    m_id_o     = id_q;
    m_len_o    = '0;
    m_size_o   = size_q;
    m_burst_o  = burst_q;
    m_valid_o  = 1'b0;
    cnt_push_o = 1'b0;
    cnt_len_o  = ax_len_i;

    unique case (state_q)
      Idle: begin
        m_addr_o  = ax_addr_i;
        m_id_o    = ax_id_i;
        m_size_o  = ax_size_i;
        m_burst_o = ax_burst_i;
        if (ax_valid_i && !cnt_full_i) begin
          m_valid_o = 1'b1;
          if (ax_len_i == '0) begin
            // Single beat goes through untouched
            ax_ready_o = m_ready_i;
            cnt_push_o = m_ready_i;
          end else begin
            // Capture the burst and offer its first beat right away
            ax_ready_o = 1'b1;
            cnt_push_o = 1'b1;
            id_d       = ax_id_i;
            size_d     = ax_size_i;
            burst_d    = ax_burst_i;
            if (m_ready_i) begin
              len_d  = ax_len_i - len_t'(1);
              addr_d = next_addr(ax_addr_i, ax_size_i, ax_burst_i);
            end else begin
              len_d  = ax_len_i;
              addr_d = ax_addr_i;
            end
            state_d = Busy;
          end
        end
      end

      Busy: begin
        m_valid_o = 1'b1;
        if (m_ready_i) begin
          if (len_q == '0) begin
            state_d = Idle;
          end else begin
            len_d  = len_q - len_t'(1);
            addr_d = next_addr(addr_q, size_q, burst_q);
          end
        end
      end

      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Held burst fields
  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    id_q    <= id_d;
    len_q   <= len_d;
    size_q  <= size_d;
    burst_q <= burst_d;
  end

endmodule

`default_nettype wire

//--- rtl/beat_count_fifo.sv
/* In-order FIFO of outstanding burst beat counts. Responses must come back in
   request order; a push while full is dropped. */
`timescale 1ns/100ps
`default_nettype none

`include "burst_split_config.svh"

module beat_count_fifo import burst_split_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  // Burst entry
  input  wire logic push_i,
  input  wire len_t push_len_i,
  output logic      full_o,
  // Beat consumption at the head
  input  wire logic take_i,
  input  wire logic set_err_i,
  output logic      head_valid_o,
  output logic      head_last_o,
  output logic      head_err_o
);

  localparam int DEPTH = `BS_MAX_TXNS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  cnt_t               cnt_mem [DEPTH];
  logic [DEPTH-1:0]   err_mem;
  logic [PTR_W-1:0]   wr_ptr, rd_ptr;
  logic [PTR_W:0]     fill;
  logic               do_push, do_take, do_pop;

  assign full_o       = (fill == (PTR_W+1)'(DEPTH));
  assign head_valid_o = (fill != '0);
  // The one place that decides the final beat of a burst
  assign head_last_o  = head_valid_o && (cnt_mem[rd_ptr] == cnt_t'(1));
  assign head_err_o   = err_mem[rd_ptr] | (take_i & set_err_i);

  assign do_push = push_i && !full_o;
  assign do_take = take_i && head_valid_o;
  assign do_pop  = do_take && head_last_o;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      fill <= fill + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  // Per-entry beat count and sticky error bit
  always_ff @(posedge clk_i) begin
    if (do_take) begin
      cnt_mem[rd_ptr] <= cnt_mem[rd_ptr] - cnt_t'(1);
      if (set_err_i) begin
        err_mem[rd_ptr] <= 1'b1;
      end
    end
    if (do_push) begin
      cnt_mem[wr_ptr] <= cnt_t'(push_len_i) + cnt_t'(1);
      err_mem[wr_ptr] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/b_merger.sv
/* Folds the per-beat write responses of a burst into one upstream response.
   The final response carries SLVERR if any beat of the burst failed. */
`timescale 1ns/100ps
`default_nettype none

`include "burst_split_config.svh"

module b_merger import burst_split_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  // Downstream B
  input  wire id_t   m_b_id_i,
  input  wire resp_t m_b_resp_i,
  input  wire logic  m_b_valid_i,
  output logic       m_b_ready_o,
  // Upstream B
  output id_t        b_id_o,
  output resp_t      b_resp_o,
  output logic       b_valid_o,
  input  wire logic  b_ready_i,
  // Write beat count FIFO
  output logic       cnt_take_o,
  output logic       cnt_set_err_o,
  input  wire logic  cnt_valid_i,
  input  wire logic  cnt_last_i,
  input  wire logic  cnt_err_i
);

  b_state_e state_q, state_d;
  logic     err_q, err_d;

  // Error level of the current beat, counted by the FIFO only on a take
  assign cnt_set_err_o = m_b_resp_i[1];
  assign b_id_o        = m_b_id_i;

  always_comb begin
    state_d     = state_q;
    err_d       = err_q;
    m_b_ready_o = 1'b0;
    b_valid_o   = 1'b0;
    b_resp_o    = m_b_resp_i;
    cnt_take_o  = 1'b0;

    unique case (state_q)
      BReady: begin
        if (m_b_valid_i && cnt_valid_i) begin
          cnt_take_o = 1'b1;
          if (cnt_last_i) begin
            b_valid_o = 1'b1;
            if (cnt_err_i) begin
              b_resp_o = `BS_RESP_SLVERR;
            end
            if (b_ready_i) begin
              m_b_ready_o = 1'b1;
            end else begin
              // Beat already taken, hold the merged error until upstream accepts
              state_d = BWait;
              err_d   = cnt_err_i;
            end
          end else begin
            // Intermediate beat is swallowed
            m_b_ready_o = 1'b1;
          end
        end
      end

      BWait: begin
        b_valid_o = 1'b1;
        if (err_q) begin
          b_resp_o = `BS_RESP_SLVERR;
        end
        if (m_b_valid_i && b_ready_i) begin
          m_b_ready_o = 1'b1;
          state_d     = BReady;
        end
      end

      default: state_d = BReady;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BReady;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/r_last_gen.sv
/* Passes read beats upstream and rebuilds last from the read beat count FIFO.
   Read data must return in request order. */
`timescale 1ns/100ps
`default_nettype none

module r_last_gen import burst_split_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  // Downstream R
  input  wire data_t m_r_data_i,
  input  wire id_t   m_r_id_i,
  input  wire resp_t m_r_resp_i,
  input  wire logic  m_r_valid_i,
  output logic       m_r_ready_o,
  // Upstream R
  output data_t      r_data_o,
  output id_t        r_id_o,
  output resp_t      r_resp_o,
  output logic       r_last_o,
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  // Read beat count FIFO
  output logic       cnt_take_o,
  input  wire logic  cnt_valid_i,
  input  wire logic  cnt_last_i
);

  r_state_e state_q, state_d;
  logic     last_q, last_d;

  assign r_data_o = m_r_data_i;
  assign r_id_o   = m_r_id_i;
  assign r_resp_o = m_r_resp_i;

  always_comb begin
    state_d     = state_q;
    last_d      = last_q;
    m_r_ready_o = 1'b0;
    r_last_o    = 1'b0;
    r_valid_o   = 1'b0;
    cnt_take_o  = 1'b0;

    unique case (state_q)
      RFeed: begin
        if (m_r_valid_i && cnt_valid_i) begin
          cnt_take_o = 1'b1;
          r_last_o   = cnt_last_i;
          r_valid_o  = 1'b1;
          if (r_ready_i) begin
            m_r_ready_o = 1'b1;
          end else begin
            state_d = RWait;
            last_d  = cnt_last_i;
          end
        end
      end

      // Count already consumed, replay the stored last flag
      RWait: begin
        r_last_o  = last_q;
        r_valid_o = 1'b1;
        if (m_r_valid_i && r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = RFeed;
        end
      end

      default: state_d = RFeed;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RFeed;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/burst_splitter_top.sv
/* AXI4 burst splitter without user signals. WRAP bursts and atomics must not occur
   upstream, and downstream must respond in request order. */
`timescale 1ns/100ps
`default_nettype none

module burst_splitter_top import burst_split_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  // Upstream AW
  input  wire addr_t  aw_addr_i,
  input  wire id_t    aw_id_i,
  input  wire len_t   aw_len_i,
  input  wire size_t  aw_size_i,
  input  wire burst_t aw_burst_i,
  input  wire logic   aw_valid_i,
  output logic        aw_ready_o,
  // Upstream W
  input  wire data_t  w_data_i,
  input  wire strb_t  w_strb_i,
  input  wire logic   w_last_i,
  input  wire logic   w_valid_i,
  output logic        w_ready_o,
  // Upstream B
  output id_t         b_id_o,
  output resp_t       b_resp_o,
  output logic        b_valid_o,
  input  wire logic   b_ready_i,
  // Upstream AR
  input  wire addr_t  ar_addr_i,
  input  wire id_t    ar_id_i,
  input  wire len_t   ar_len_i,
  input  wire size_t  ar_size_i,
  input  wire burst_t ar_burst_i,
  input  wire logic   ar_valid_i,
  output logic        ar_ready_o,
  // Upstream R
  output data_t       r_data_o,
  output id_t         r_id_o,
  output resp_t       r_resp_o,
  output logic        r_last_o,
  output logic        r_valid_o,
  input  wire logic   r_ready_i,
  // Downstream AW
  output addr_t       m_aw_addr_o,
  output id_t         m_aw_id_o,
  output len_t        m_aw_len_o,
  output size_t       m_aw_size_o,
  output burst_t      m_aw_burst_o,
  output logic        m_aw_valid_o,
  input  wire logic   m_aw_ready_i,
  // Downstream W
  output data_t       m_w_data_o,
  output strb_t       m_w_strb_o,
  output logic        m_w_last_o,
  output logic        m_w_valid_o,
  input  wire logic   m_w_ready_i,
  // Downstream B
  input  wire id_t    m_b_id_i,
  input  wire resp_t  m_b_resp_i,
  input  wire logic   m_b_valid_i,
  output logic        m_b_ready_o,
  // Downstream AR
  output addr_t       m_ar_addr_o,
  output id_t         m_ar_id_o,
  output len_t        m_ar_len_o,
  output size_t       m_ar_size_o,
  output burst_t      m_ar_burst_o,
  output logic        m_ar_valid_o,
  input  wire logic   m_ar_ready_i,
  // Downstream R
  input  wire data_t  m_r_data_i,
  input  wire id_t    m_r_id_i,
  input  wire resp_t  m_r_resp_i,
  input  wire logic   m_r_last_i,
  input  wire logic   m_r_valid_i,
  output logic        m_r_ready_o
);

  logic w_push, w_full, w_take, w_set_err, w_head_valid, w_head_last, w_head_err;
  logic r_push, r_full, r_take, r_head_valid, r_head_last;
  len_t w_push_len, r_push_len;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  ax_splitter u_aw_split (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ax_addr_i  (aw_addr_i),
    .ax_id_i    (aw_id_i),
    .ax_len_i   (aw_len_i),
    .ax_size_i  (aw_size_i),
    .ax_burst_i (aw_burst_i),
    .ax_valid_i (aw_valid_i),
    .ax_ready_o (aw_ready_o),
    .m_addr_o   (m_aw_addr_o),
    .m_id_o     (m_aw_id_o),
    .m_len_o    (m_aw_len_o),
    .m_size_o   (m_aw_size_o),
    .m_burst_o  (m_aw_burst_o),
    .m_valid_o  (m_aw_valid_o),
    .m_ready_i  (m_aw_ready_i),
    .cnt_push_o (w_push),
    .cnt_len_o  (w_push_len),
    .cnt_full_i (w_full)
  );

  beat_count_fifo u_w_cnt (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (w_push),
    .push_len_i   (w_push_len),
    .full_o       (w_full),
    .take_i       (w_take),
    .set_err_i    (w_set_err),
    .head_valid_o (w_head_valid),
    .head_last_o  (w_head_last),
    .head_err_o   (w_head_err)
  );

  // Each downstream beat is a burst of its own, so last is always high.
  // The upstream last flag carries no extra information here
  assign m_w_data_o  = w_data_i;
  assign m_w_strb_o  = w_strb_i;
  assign m_w_last_o  = 1'b1;
  assign m_w_valid_o = w_valid_i;
  assign w_ready_o   = m_w_ready_i;

  b_merger u_b_merge (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .m_b_id_i      (m_b_id_i),
    .m_b_resp_i    (m_b_resp_i),
    .m_b_valid_i   (m_b_valid_i),
    .m_b_ready_o   (m_b_ready_o),
    .b_id_o        (b_id_o),
    .b_resp_o      (b_resp_o),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .cnt_take_o    (w_take),
    .cnt_set_err_o (w_set_err),
    .cnt_valid_i   (w_head_valid),
    .cnt_last_i    (w_head_last),
    .cnt_err_i     (w_head_err)
  );

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  ax_splitter u_ar_split (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ax_addr_i  (ar_addr_i),
    .ax_id_i    (ar_id_i),
    .ax_len_i   (ar_len_i),
    .ax_size_i  (ar_size_i),
    .ax_burst_i (ar_burst_i),
    .ax_valid_i (ar_valid_i),
    .ax_ready_o (ar_ready_o),
    .m_addr_o   (m_ar_addr_o),
    .m_id_o     (m_ar_id_o),
    .m_len_o    (m_ar_len_o),
    .m_size_o   (m_ar_size_o),
    .m_burst_o  (m_ar_burst_o),
    .m_valid_o  (m_ar_valid_o),
    .m_ready_i  (m_ar_ready_i),
    .cnt_push_o (r_push),
    .cnt_len_o  (r_push_len),
    .cnt_full_i (r_full)
  );

  // Read errors go out per beat, nothing to merge
  beat_count_fifo u_r_cnt (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (r_push),
    .push_len_i   (r_push_len),
    .full_o       (r_full),
    .take_i       (r_take),
    .set_err_i    (1'b0),
    .head_valid_o (r_head_valid),
    .head_last_o  (r_head_last),
    .head_err_o   ()
  );

  // Downstream last is ignored, every downstream read is one beat
  r_last_gen u_r_last (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_id_i    (m_r_id_i),
    .m_r_resp_i  (m_r_resp_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .r_data_o    (r_data_o),
    .r_id_o      (r_id_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .cnt_take_o  (r_take),
    .cnt_valid_i (r_head_valid),
    .cnt_last_i  (r_head_last)
  );

endmodule

`default_nettype wire

//--- dv/clk_rst_gen.sv
/* Free-running testbench clock and an active-low reset held for a few cycles.
   Reset is released on a falling edge. */
`timescale 1ns/100ps
`default_nettype none

module clk_rst_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_burst_splitter.sv
/* Table-driven test of the burst splitter. The downstream slave model answers in
   request order and returns the beat address as read data. */
`timescale 1ns/100ps
`default_nettype none

`include "burst_split_config.svh"

module tb_burst_splitter import burst_split_pkg::*; ();

  localparam int TIMEOUT    = 2000;
  localparam int N_DIRECTED = 5;

  typedef struct {
    string  name;
    bit     is_write;
    burst_t burst;
    len_t   len;
    size_t  size;
    addr_t  addr;
    int     err_beat;
  } row_t;

  // One expected or pending beat; row doubles as the AXI ID
  typedef struct {
    int          row;
    int          beat;
    logic [31:0] val;
    resp_t       resp;
    bit          last;
  } exp_t;

  logic   clk_i, rst_n_i;
  addr_t  aw_addr_i, ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  id_t    aw_id_i, ar_id_i, b_id_o, r_id_o, m_aw_id_o, m_ar_id_o, m_b_id_i, m_r_id_i;
  len_t   aw_len_i, ar_len_i, m_aw_len_o, m_ar_len_o;
  size_t  aw_size_i, ar_size_i, m_aw_size_o, m_ar_size_o;
  burst_t aw_burst_i, ar_burst_i, m_aw_burst_o, m_ar_burst_o;
  data_t  w_data_i, r_data_o, m_w_data_o, m_r_data_i;
  strb_t  w_strb_i, m_w_strb_o;
  resp_t  b_resp_o, r_resp_o, m_b_resp_i, m_r_resp_i;
  logic   aw_valid_i, aw_ready_o, w_last_i, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic   ar_valid_i, ar_ready_o, r_last_o, r_valid_o, r_ready_i;
  logic   m_aw_valid_o, m_aw_ready_i, m_w_last_o, m_w_valid_o, m_w_ready_i;
  logic   m_b_valid_i, m_b_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic   m_r_last_i, m_r_valid_i, m_r_ready_o;

  row_t        rows[$];
  exp_t        exp_aw[$], exp_ar[$], exp_w[$], exp_b[$], exp_r[$];
  exp_t        b_pend[$], r_pend[$];
  exp_t        mon_e, pend_e;
  logic [31:0] rnd = 32'h72a9_13cb;
  bit          stress = 1'b0;
  int          w_beats, b_done, checks, errors;

  clk_rst_gen u_clk_rst (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  burst_splitter_top UUT (.*);

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // INCR steps by 2**size bytes per beat, FIXED stays put
  function automatic addr_t beat_addr(input int r, input int beat);
    if (rows[r].burst == `BS_BURST_INCR) begin
      return rows[r].addr + addr_t'(beat) * (addr_t'(1) << rows[r].size);
    end
    return rows[r].addr;
  endfunction

  function automatic data_t write_data(input int r, input int beat);
    return 32'hd000_0000 | (32'(r) << 8) | 32'(beat);
  endfunction

  function automatic strb_t write_strb(input int r, input int beat);
    return strb_t'(r * 3 + beat + 1);
  endfunction

  task automatic add_row(input string name, input bit is_write, input burst_t burst,
                         input len_t len, input size_t size, input addr_t addr,
                         input int err_beat);
    row_t row;
    row.name     = name;
    row.is_write = is_write;
    row.burst    = burst;
    row.len      = len;
    row.size     = size;
    row.addr     = addr;
    row.err_beat = err_beat;
    rows.push_back(row);
  endtask

  task automatic compare(input int row, input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s %s: expected 0x%h, actual 0x%h",
               rows[row].name, what, expected, actual);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Problem: %s", msg);
  endtask

  // Called on a falling edge, returns on a falling edge with all valids low
  task automatic send_burst(input int r);
    exp_t e;
    bit   any_err;
    bit   accepted;
    int   waited;
    any_err = 1'b0;
    for (int i = 0; i <= int'(rows[r].len); i++) begin
      e.row  = r;
      e.beat = i;
      e.val  = beat_addr(r, i);
      e.resp = (i == rows[r].err_beat) ? `BS_RESP_SLVERR : `BS_RESP_OKAY;
      e.last = (i == int'(rows[r].len));
      if (i == rows[r].err_beat) begin
        any_err = 1'b1;
      end
      if (rows[r].is_write) begin
        exp_aw.push_back(e);
        e.val = write_data(r, i);
        exp_w.push_back(e);
      end else begin
        exp_ar.push_back(e);
        exp_r.push_back(e);
      end
    end
    if (rows[r].is_write) begin
      e.row  = r;
      e.val  = '0;
      e.resp = any_err ? `BS_RESP_SLVERR : `BS_RESP_OKAY;
      e.last = 1'b1;
      exp_b.push_back(e);
      aw_addr_i  = rows[r].addr;
      aw_id_i    = id_t'(r);
      aw_len_i   = rows[r].len;
      aw_size_i  = rows[r].size;
      aw_burst_i = rows[r].burst;
      aw_valid_i = 1'b1;
    end else begin
      ar_addr_i  = rows[r].addr;
      ar_id_i    = id_t'(r);
      ar_len_i   = rows[r].len;
      ar_size_i  = rows[r].size;
      ar_burst_i = rows[r].burst;
      ar_valid_i = 1'b1;
    end
    accepted = 1'b0;
    for (waited = 0; waited < TIMEOUT && !accepted; waited++) begin
      @(posedge clk_i);
      accepted = rows[r].is_write ? aw_ready_o : ar_ready_o;
    end
    if (!accepted) begin
      report_problem({"address request of ", rows[r].name, " was never accepted"});
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    if (rows[r].is_write) begin
      for (int i = 0; i <= int'(rows[r].len); i++) begin
        w_data_i  = write_data(r, i);
        w_strb_i  = write_strb(r, i);
        w_last_i  = (i == int'(rows[r].len));
        w_valid_i = 1'b1;
        accepted  = 1'b0;
        for (waited = 0; waited < TIMEOUT && !accepted; waited++) begin
          @(posedge clk_i);
          accepted = w_ready_o;
        end
        if (!accepted) begin
          report_problem({"write data of ", rows[r].name, " was never accepted"});
        end
        @(negedge clk_i);
      end
      w_valid_i = 1'b0;
    end
  endtask

  // Wait until every expected beat and response has been seen
  task automatic drain();
    bit empty;
    int waited;
    empty = 1'b0;
    for (waited = 0; waited < TIMEOUT && !empty; waited++) begin
      @(posedge clk_i);
      empty = (exp_aw.size() == 0) && (exp_w.size() == 0) && (exp_b.size() == 0) &&
              (exp_ar.size() == 0) && (exp_r.size() == 0) &&
              (b_pend.size() == 0) && (r_pend.size() == 0);
    end
    if (!empty) begin
      report_problem("outstanding transfers did not complete in time");
    end
  endtask

  // --------------------------------------------------
  // Slave model drive and ready toggling
  // --------------------------------------------------
  always @(negedge clk_i) begin
    rnd = xorshift32(rnd);
    if (stress) begin
      m_aw_ready_i = rnd[0] | rnd[1];
      m_w_ready_i  = rnd[2] | rnd[3];
      m_ar_ready_i = rnd[4] | rnd[5];
      b_ready_i    = rnd[6] | rnd[7];
      r_ready_i    = rnd[8] | rnd[9];
    end else begin
      m_aw_ready_i = 1'b1;
      m_w_ready_i  = 1'b1;
      m_ar_ready_i = 1'b1;
      b_ready_i    = 1'b1;
      r_ready_i    = 1'b1;
    end
    // A write response needs both its address and its data beat
    m_b_valid_i = (b_pend.size() != 0) && (w_beats > b_done);
    if (m_b_valid_i) begin
      m_b_id_i   = id_t'(b_pend[0].row);
      m_b_resp_i = b_pend[0].resp;
    end
    m_r_valid_i = (r_pend.size() != 0);
    if (m_r_valid_i) begin
      m_r_data_i = r_pend[0].val;
      m_r_id_i   = id_t'(r_pend[0].row);
      m_r_resp_i = r_pend[0].resp;
      m_r_last_i = 1'b1;
    end
  end

  // --------------------------------------------------
  // Handshake monitors and checks
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        if (exp_aw.size() == 0) begin
          report_problem("unexpected downstream write address");
        end else begin
          mon_e = exp_aw.pop_front();
          compare(mon_e.row, "aw addr", mon_e.val, m_aw_addr_o);
          compare(mon_e.row, "aw len", 32'h0, 32'(m_aw_len_o));
          compare(mon_e.row, "aw size", 32'(rows[mon_e.row].size), 32'(m_aw_size_o));
          compare(mon_e.row, "aw burst", 32'(rows[mon_e.row].burst), 32'(m_aw_burst_o));
          compare(mon_e.row, "aw id", 32'(mon_e.row), 32'(m_aw_id_o));
          pend_e      = mon_e;
          pend_e.row  = int'(m_aw_id_o);
          b_pend.push_back(pend_e);
        end
      end
      if (m_w_valid_o && m_w_ready_i) begin
        w_beats++;
        if (exp_w.size() == 0) begin
          report_problem("unexpected downstream write data");
        end else begin
          mon_e = exp_w.pop_front();
          compare(mon_e.row, "w data", mon_e.val, m_w_data_o);
          compare(mon_e.row, "w strb", 32'(write_strb(mon_e.row, mon_e.beat)),
                  32'(m_w_strb_o));
          compare(mon_e.row, "w last", 32'h1, 32'(m_w_last_o));
        end
      end
      if (m_b_valid_i && m_b_ready_o) begin
        void'(b_pend.pop_front());
        b_done++;
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_b.size() == 0) begin
          report_problem("unexpected upstream write response");
        end else begin
          mon_e = exp_b.pop_front();
          compare(mon_e.row, "b resp", 32'(mon_e.resp), 32'(b_resp_o));
          compare(mon_e.row, "b id", 32'(mon_e.row), 32'(b_id_o));
        end
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (exp_ar.size() == 0) begin
          report_problem("unexpected downstream read address");
        end else begin
          mon_e = exp_ar.pop_front();
          compare(mon_e.row, "ar addr", mon_e.val, m_ar_addr_o);
          compare(mon_e.row, "ar len", 32'h0, 32'(m_ar_len_o));
          compare(mon_e.row, "ar size", 32'(rows[mon_e.row].size), 32'(m_ar_size_o));
          compare(mon_e.row, "ar burst", 32'(rows[mon_e.row].burst), 32'(m_ar_burst_o));
          compare(mon_e.row, "ar id", 32'(mon_e.row), 32'(m_ar_id_o));
          // Read data is the address of the beat
          pend_e     = mon_e;
          pend_e.row = int'(m_ar_id_o);
          pend_e.val = m_ar_addr_o;
          r_pend.push_back(pend_e);
        end
      end
      if (m_r_valid_i && m_r_ready_o) begin
        void'(r_pend.pop_front());
      end
      if (r_valid_o && r_ready_i) begin
        if (exp_r.size() == 0) begin
          report_problem("unexpected upstream read beat");
        end else begin
          mon_e = exp_r.pop_front();
          compare(mon_e.row, "r data", mon_e.val, r_data_o);
          compare(mon_e.row, "r resp", 32'(mon_e.resp), 32'(r_resp_o));
          compare(mon_e.row, "r last", 32'(mon_e.last), 32'(r_last_o));
          compare(mon_e.row, "r id", 32'(mon_e.row), 32'(r_id_o));
        end
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int waited;
    w_beats = 0;
    b_done  = 0;
    checks  = 0;
    errors  = 0;
    {aw_addr_i, aw_id_i, aw_len_i, aw_size_i, aw_burst_i, aw_valid_i} = '0;
    {ar_addr_i, ar_id_i, ar_len_i, ar_size_i, ar_burst_i, ar_valid_i} = '0;
    {w_data_i, w_strb_i, w_last_i, w_valid_i} = '0;
    w_strb_i = '1;
    {b_ready_i, r_ready_i, m_aw_ready_i, m_w_ready_i, m_ar_ready_i} = '0;
    {m_b_id_i, m_b_resp_i, m_b_valid_i} = '0;
    {m_r_data_i, m_r_id_i, m_r_resp_i, m_r_last_i, m_r_valid_i} = '0;

    // Name, write, burst, len, size, address, error beat (-1 for none)
    add_row("single_write", 1'b1, `BS_BURST_INCR,  8'd0,  3'd2, 32'h0000_1000, -1);
    add_row("incr_write",   1'b1, `BS_BURST_INCR,  8'd7,  3'd2, 32'h0000_2000, -1);
    add_row("fixed_read",   1'b0, `BS_BURST_FIXED, 8'd5,  3'd2, 32'h0000_3000, -1);
    add_row("error_write",  1'b1, `BS_BURST_INCR,  8'd4,  3'd3, 32'h0000_4000, 2);
    add_row("clean_write",  1'b1, `BS_BURST_INCR,  8'd4,  3'd3, 32'h0000_5000, -1);
    add_row("stress_wr0",   1'b1, `BS_BURST_INCR,  8'd3,  3'd1, 32'h0000_6000, -1);
    add_row("stress_rd0",   1'b0, `BS_BURST_INCR,  8'd6,  3'd2, 32'h0000_7000, 3);
    add_row("stress_wr1",   1'b1, `BS_BURST_FIXED, 8'd2,  3'd2, 32'h0000_8000, 1);
    add_row("stress_rd1",   1'b0, `BS_BURST_FIXED, 8'd0,  3'd2, 32'h0000_9000, -1);
    add_row("stress_wr2",   1'b1, `BS_BURST_INCR,  8'd15, 3'd0, 32'h0000_a000, -1);
    add_row("stress_rd2",   1'b0, `BS_BURST_INCR,  8'd3,  3'd3, 32'h0000_b000, -1);
    add_row("stress_wr3",   1'b1, `BS_BURST_INCR,  8'd1,  3'd2, 32'h0000_c000, 0);
    add_row("stress_rd3",   1'b0, `BS_BURST_INCR,  8'd2,  3'd1, 32'h0000_d000, -1);
    add_row("stress_wr4",   1'b1, `BS_BURST_INCR,  8'd0,  3'd2, 32'h0000_e000, -1);

    for (waited = 0; waited < TIMEOUT && !rst_n_i; waited++) begin
      @(posedge clk_i);
    end
    if (!rst_n_i) begin
      report_problem("reset was never released");
    end

    // Directed rows, one burst at a time with all ready signals high
    for (int r = 0; r < N_DIRECTED; r++) begin
      @(negedge clk_i);
      send_burst(r);
      drain();
    end

    // Remaining rows back to back under random back-pressure
    stress = 1'b1;
    @(negedge clk_i);
    for (int r = N_DIRECTED; r < rows.size(); r++) begin
      send_burst(r);
    end
    drain();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/burst_split_pkg.sv
rtl/ax_splitter.sv
rtl/beat_count_fifo.sv
rtl/b_merger.sv
rtl/r_last_gen.sv
rtl/burst_splitter_top.sv
dv/clk_rst_gen.sv
dv/tb_burst_splitter.sv

//--- Makefile
SIM      := verilator
TOP      := tb_burst_splitter
FILELIST := sources.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR)
LOG      := sim.log

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
